// ==== list.f ====
+incdir+tb
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_data_mem.sv
design/rv_control.sv
design/rv_core.sv
tb/tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the rv_core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_rv_core -f list.f -o tb_rv_core_sim

./obj_dir/tb_rv_core_sim 2>&1 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// ==== tb/tb_rv_tests.svh ====
`ifndef TB_RV_TESTS_SVH
`define TB_RV_TESTS_SVH

// ==========================================================================
// rv32i encoders
// ==========================================================================
function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                input reg_addr_t rs1, input logic [2:0] f3,
                                input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                input logic [2:0] f3, input reg_addr_t rd,
                                input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

// branch condition straight from the isa
function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        default: return a >= b;
    endcase
endfunction

// ==========================================================================
// directed tests
// ==========================================================================
task automatic test_reset();
    for (int n = 0; n < 2; n++) begin  // second pass sees cleared regs
        expect_write(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'd0);
        expect_write(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM), 5'd1, 32'd5);
        expect_write(enc_i(12'd1, 5'd1, 3'b000, 5'd2, OP_IMM), 5'd2, 32'd6);
        run_program();
    end
endtask

task automatic test_alu();
    logic [11:0] ia;
    logic [11:0] ib;
    logic [19:0] u;
    logic [4:0]  sh;
    word_t       a;
    word_t       b;
    word_t       lt;
    word_t       ltu;
    ia  = 12'($urandom);
    ib  = 12'($urandom);
    u   = 20'($urandom);
    a   = {{20{ia[11]}}, ia};
    b   = {{20{ib[11]}}, ib};
    sh  = ib[4:0];
    lt  = {31'd0, $signed(a) < $signed(b)};
    ltu = {31'd0, a < b};
    expect_write(enc_i(ia, 5'd0, 3'b000, 5'd1, OP_IMM), 5'd1, a);
    expect_write(enc_i(ib, 5'd0, 3'b000, 5'd2, OP_IMM), 5'd2, b);
    expect_write(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, a + b);  // add
    expect_write(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, a - b);  // sub
    expect_write(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd3), 5'd3, lt);
    expect_write(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd3), 5'd3, ltu);
    expect_write(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), 5'd3, a ^ b);
    expect_write(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), 5'd3, a | b);
    expect_write(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), 5'd3, a & b);
    expect_write(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd3), 5'd3, a << sh);  // sll
    expect_write(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd3), 5'd3, a >> sh);  // srl
    expect_write(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3), 5'd3,
                 word_t'($signed(a) >>> sh));                             // sra
    expect_write(enc_i(ib, 5'd1, 3'b000, 5'd4, OP_IMM), 5'd4, a + b);
    expect_write(enc_i(ib, 5'd1, 3'b010, 5'd4, OP_IMM), 5'd4, lt);
    expect_write(enc_i(ib, 5'd1, 3'b011, 5'd4, OP_IMM), 5'd4, ltu);     // sltiu
    expect_write(enc_i(ib, 5'd1, 3'b100, 5'd4, OP_IMM), 5'd4, a ^ b);
    expect_write(enc_i(ib, 5'd1, 3'b110, 5'd4, OP_IMM), 5'd4, a | b);
    expect_write(enc_i(ib, 5'd1, 3'b111, 5'd4, OP_IMM), 5'd4, a & b);
    expect_write(enc_i({7'h00, sh}, 5'd1, 3'b001, 5'd4, OP_IMM), 5'd4, a << sh);
    expect_write(enc_i({7'h00, sh}, 5'd1, 3'b101, 5'd4, OP_IMM), 5'd4, a >> sh);
    expect_write(enc_i({7'h20, sh}, 5'd1, 3'b101, 5'd4, OP_IMM), 5'd4,
                 word_t'($signed(a) >>> sh));                             // srai
    expect_write(enc_u(u, 5'd5, OP_LUI), 5'd5, {u, 12'd0});
    expect_write(enc_u(u, 5'd6, OP_AUIPC), 5'd6, here() + {u, 12'd0});  // pc + upper
    run_program();
endtask

task automatic test_mem();
    word_t       v;
    word_t       w4;
    logic [19:0] hi;
    v  = $urandom;
    hi = 20'((v + 32'h800) >> 12);  // addi below adds sign-extended low bits
    w4 = {v[15:0], 8'h00, v[7:0]};   // word 260 after sw 0, sb, sh
    expect_write(enc_i(12'd256, 5'd0, 3'b000, 5'd1, OP_IMM), 5'd1, 32'd256);  // base
    expect_write(enc_u(hi, 5'd2, OP_LUI), 5'd2, {hi, 12'd0});
    expect_write(enc_i(v[11:0], 5'd2, 3'b000, 5'd2, OP_IMM), 5'd2, v);
    emit(enc_s(12'd0, 5'd2, 5'd1, 3'b010));                                   // sw
    expect_write(enc_i(12'd0, 5'd1, 3'b010, 5'd3, OP_LOAD), 5'd3, v);
    expect_write(enc_i(12'd2, 5'd1, 3'b001, 5'd3, OP_LOAD), 5'd3,
                 {{16{v[31]}}, v[31:16]});                                    // lh
    expect_write(enc_i(12'd0, 5'd1, 3'b101, 5'd3, OP_LOAD), 5'd3, {16'd0, v[15:0]});
    expect_write(enc_i(12'd3, 5'd1, 3'b000, 5'd3, OP_LOAD), 5'd3,
                 {{24{v[31]}}, v[31:24]});                                    // lb
    expect_write(enc_i(12'd1, 5'd1, 3'b100, 5'd3, OP_LOAD), 5'd3, {24'd0, v[15:8]});
    emit(enc_s(12'd4, 5'd0, 5'd1, 3'b010));  // clear word 260
    emit(enc_s(12'd4, 5'd2, 5'd1, 3'b000));  // sb
    emit(enc_s(12'd6, 5'd2, 5'd1, 3'b001));  // sh upper half
    expect_write(enc_i(12'd4, 5'd1, 3'b010, 5'd3, OP_LOAD), 5'd3, w4);
    expect_write(enc_i(12'd4, 5'd1, 3'b000, 5'd3, OP_LOAD), 5'd3, {{24{v[7]}}, v[7:0]});
    expect_write(enc_i(12'd6, 5'd1, 3'b101, 5'd3, OP_LOAD), 5'd3, {16'd0, v[15:0]});
    emit(enc_s(12'd1, 5'd0, 5'd1, 3'b010));  // misaligned sw is dropped
    emit(enc_s(12'd5, 5'd0, 5'd1, 3'b001));  // misaligned sh is dropped
    expect_write(enc_i(12'd0, 5'd1, 3'b010, 5'd3, OP_LOAD), 5'd3, v);
    expect_write(enc_i(12'd4, 5'd1, 3'b010, 5'd3, OP_LOAD), 5'd3, w4);
    expect_write(enc_u(20'd1, 5'd4, OP_LUI), 5'd4, 32'd4096);                 // past end
    expect_write(enc_i(12'd256, 5'd4, 3'b010, 5'd3, OP_LOAD), 5'd3, 32'd0);  // would alias 256
    run_program();
endtask

task automatic test_branch();
    logic [2:0]  kinds [6];
    word_t       regs [4];  // x0..x2 as loaded
    logic [11:0] ia;
    logic [11:0] ib;
    reg_addr_t   s1;
    reg_addr_t   s2;
    word_t       marker;
    kinds   = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    ia      = 12'($urandom);
    ib      = ia ^ 12'h801;  // opposite sign and other lsb
    regs[0] = '0;
    regs[1] = {{20{ia[11]}}, ia};
    regs[2] = {{20{ib[11]}}, ib};
    regs[3] = '0;
    expect_write(enc_i(ia, 5'd0, 3'b000, 5'd1, OP_IMM), 5'd1, regs[1]);
    expect_write(enc_i(ib, 5'd0, 3'b000, 5'd2, OP_IMM), 5'd2, regs[2]);
    foreach (kinds[k]) begin
        for (int p = 0; p < 3; p++) begin  // pairs (x1,x2) (x2,x1) (x1,x1)
            s1     = (p == 1) ? 5'd2 : 5'd1;
            s2     = (p == 0) ? 5'd2 : 5'd1;
            marker = word_t'(k * 3 + p + 1);
            emit(enc_b(13'd8, s2, s1, kinds[k]));  // taken skips the marker
            if (branch_ref(kinds[k], regs[s1[1:0]], regs[s2[1:0]])) begin
                place_unreached(enc_i(marker[11:0], 5'd0, 3'b000, 5'd7, OP_IMM));
            end else begin
                expect_write(enc_i(marker[11:0], 5'd0, 3'b000, 5'd7, OP_IMM), 5'd7, marker);
            end
        end
    end
    run_program();
endtask

task automatic test_jump();
    expect_write(enc_j(21'd12, 5'd1), 5'd1, here() + 4);                       // jal 0 to 12
    place_unreached(enc_i(12'd1, 5'd0, 3'b000, 5'd9, OP_IMM));
    place_unreached(enc_i(12'd2, 5'd0, 3'b000, 5'd9, OP_IMM));
    expect_write(enc_i(12'd27, 5'd0, 3'b000, 5'd2, OP_IMM), 5'd2, 32'd27);     // odd base
    expect_write(enc_i(12'd2, 5'd2, 3'b000, 5'd3, OP_JALR), 5'd3, here() + 4); // 29 -> 28
    place_unreached(enc_i(12'd3, 5'd0, 3'b000, 5'd9, OP_IMM));
    place_unreached(enc_i(12'd4, 5'd0, 3'b000, 5'd9, OP_IMM));
    emit(enc_j(21'd8, 5'd0));                                                  // jal at 28 no link
    place_unreached(enc_i(12'd5, 5'd0, 3'b000, 5'd9, OP_IMM));
    emit(enc_i(12'd123, 5'd0, 3'b000, 5'd0, OP_IMM));                          // x0 write
    expect_write(enc_i(12'd9, 5'd0, 3'b000, 5'd6, OP_IMM), 5'd6, 32'd9);
    expect_write(enc_r(7'h00, 5'd6, 5'd0, 3'b000, 5'd5), 5'd5, 32'd9);        // x0 + x6
    expect_write(enc_r(7'h00, 5'd0, 5'd0, 3'b110, 5'd4), 5'd4, 32'd0);
    run_program();
endtask

task automatic test_no_writeback();
    emit(enc_s(12'd0, 5'd0, 5'd0, 3'b010));            // sw at 0
    emit(enc_b(13'd12, 5'd0, 5'd0, 3'b000));           // beq at 4 taken to 16
    place_unreached(enc_s(12'd8, 5'd0, 5'd0, 3'b000));
    place_unreached(enc_s(12'd9, 5'd0, 5'd0, 3'b000));
    emit(enc_b(13'd8, 5'd0, 5'd0, 3'b001));            // bne at 16 falls through
    emit(enc_s(12'd3, 5'd0, 5'd0, 3'b000));            // sb
    emit(enc_b(13'd8, 5'd0, 5'd0, 3'b110));            // bltu falls through
    emit(enc_b(13'd8, 5'd0, 5'd0, 3'b101));            // bge at 28 taken to 36
    place_unreached(enc_s(12'd4, 5'd0, 5'd0, 3'b010));
    emit(enc_s(12'd2, 5'd0, 5'd0, 3'b001));            // sh
    run_program();
endtask

`endif

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

    localparam word_t RESET_ADDR = 32'h0;  // rv_core default
    localparam int    IMEM_WORDS = 256;

    logic      clk;
    logic      rst_n;
    word_t     instr_addr;
    word_t     instr_data;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;

    word_t     imem [IMEM_WORDS];  // instruction memory model
    word_t     prog_q[$];          // program being built
    reg_addr_t exp_rd[$];
    word_t     exp_data[$];
    word_t     exp_fetch[$];       // predicted fetch order
    reg_addr_t got_rd[$];
    word_t     got_data[$];
    word_t     got_fetch[$];
    int        budget;             // instructions issued so far
    int        cycles;
    int        seed_ret;

    rv_core rv_core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_addr_o (instr_addr),
        .instr_data_i (instr_data),
        .wb_valid_o   (wb_valid),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data)
    );

    assign instr_data = imem[instr_addr[9:2]];  // word index, same cycle

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==========================================================================
    // timeout and monitors
    // ==========================================================================
    always @(posedge clk) begin
        cycles++;
        if (cycles > 4 * budget + 200) begin  // 4 cycles per instr worst case
            $display("run timed out after %0d cycles", cycles);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    // mid-cycle sampling, outputs settled
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            got_rd.push_back(wb_rd);
            got_data.push_back(wb_data);
        end
        if (rst_n && (got_fetch.size() == 0 || got_fetch[$] != instr_addr)) begin
            got_fetch.push_back(instr_addr);  // new pc = next fetch
        end
    end

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ==========================================================================
    // program building and running
    // ==========================================================================
    function automatic word_t here();
        return RESET_ADDR + word_t'(prog_q.size() * 4);  // addr of next slot
    endfunction

    task automatic emit(input word_t instr);  // executed, no writeback
        exp_fetch.push_back(here());
        prog_q.push_back(instr);
    endtask

    task automatic place_unreached(input word_t instr);  // jumped over
        prog_q.push_back(instr);
    endtask

    task automatic expect_write(input word_t instr, input reg_addr_t rd, input word_t value);
        exp_rd.push_back(rd);
        exp_data.push_back(value);
        emit(instr);
    endtask

    task automatic run_program();
        word_t end_addr;
        end_addr = here();
        exp_fetch.push_back(end_addr);  // first nop after the program
        budget += prog_q.size();
        @(posedge clk);
        #1 rst_n = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < prog_q.size()) ? prog_q[i] : NOP_INSTR;
        end
        got_rd.delete();
        got_data.delete();
        got_fetch.delete();
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        check("instr_addr_o", RESET_ADDR, instr_addr);
        repeat (2) begin                  // fetch and exec of first instr
            @(negedge clk);
            check("wb_valid_o", 32'd0, word_t'(wb_valid));
        end
        while (instr_addr != end_addr) begin  // done once last instr retired
            @(posedge clk);
            #1;
        end
        @(negedge clk);
        #1;
        check("writeback count", word_t'(exp_rd.size()), word_t'(got_rd.size()));
        foreach (exp_rd[i]) begin
            check("wb_rd_o", word_t'(exp_rd[i]), word_t'(got_rd[i]));
            check("wb_data_o", exp_data[i], got_data[i]);
        end
        check("fetch count", word_t'(exp_fetch.size()), word_t'(got_fetch.size()));
        foreach (exp_fetch[i]) begin
            check("instr_addr_o", exp_fetch[i], got_fetch[i]);
        end
        prog_q.delete();
        exp_rd.delete();
        exp_data.delete();
        exp_fetch.delete();
    endtask

    `include "tb_rv_tests.svh"

    initial begin
        rst_n    = 1'b0;
        budget   = 0;
        cycles   = 0;
        seed_ret = $urandom(29);
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = NOP_INSTR;
        end
        test_reset();
        test_alu();
        test_mem();
        test_branch();
        test_jump();
        test_no_writeback();
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
    parameter int    DMEM_BYTES = 4096,
    parameter word_t RESET_PC   = 32'h0
) (
    input  logic      clk,
    input  logic      rst_n,
    output word_t     instr_addr_o,  // combinational fetch
    input  word_t     instr_data_i,
    output logic      wb_valid_o,    // one per retired rd write
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    dec_t   dec;
    instr_u ir;
    word_t  pc;
    word_t  rs1_data;
    word_t  rs2_data;
    word_t  alu_result;
    logic   alu_zero;
    word_t  load_data;
    logic   mem_re;
    logic   mem_we;
    logic   rf_we;
    word_t  rf_wdata;

    rv_control #(
        .RESET_PC     (RESET_PC)
    ) rv_control_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_data_i (instr_data_i),
        .dec_i        (dec),
        .alu_result_i (alu_result),
        .alu_zero_i   (alu_zero),
        .load_data_i  (load_data),
        .pc_o         (pc),
        .instr_o      (ir),
        .mem_re_o     (mem_re),
        .mem_we_o     (mem_we),
        .rf_we_o      (rf_we),
        .rf_wdata_o   (rf_wdata)
    );

    rv_decoder rv_decoder_i (
        .instr_i (ir),
        .dec_o   (dec)
    );

    rv_regfile rv_regfile_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_i      (dec.rs1),
        .rs2_i      (dec.rs2),
        .we_i       (rf_we),
        .waddr_i    (dec.rd),
        .wdata_i    (rf_wdata),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_alu rv_alu_i (
        .dec_i      (dec),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .pc_i       (pc),
        .result_o   (alu_result),
        .zero_o     (alu_zero)
    );

    rv_data_mem #(
        .DMEM_BYTES (DMEM_BYTES)
    ) rv_data_mem_i (
        .clk        (clk),
        .re_i       (mem_re),
        .we_i       (mem_we),
        .funct3_i   (dec.funct3),
        .addr_i     (alu_result),  // rs1 + imm
        .wdata_i    (rs2_data),
        .rdata_o    (load_data)
    );

    assign instr_addr_o = pc;
    assign wb_valid_o   = rf_we;
    assign wb_rd_o      = dec.rd;
    assign wb_data_o    = rf_wdata;

endmodule

// ==== design/rv_control.sv ====
`timescale 1ns/1ps

module rv_control import rv_pkg::*; #(
    parameter word_t RESET_PC = 32'h0
) (
    input  logic   clk,
    input  logic   rst_n,
    input  word_t  instr_data_i,  // fetch data, same cycle
    input  dec_t   dec_i,
    input  word_t  alu_result_i,
    input  logic   alu_zero_i,
    input  word_t  load_data_i,
    output word_t  pc_o,          // also fetch address
    output instr_u instr_o,       // to decoder
    output logic   mem_re_o,
    output logic   mem_we_o,
    output logic   rf_we_o,
    output word_t  rf_wdata_o
);

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM,   // loads and stores only
        ST_WB
    } state_e;

    state_e state_q;
    state_e state_d;
    word_t  pc_q;
    word_t  pc_plus4;
    word_t  pc_target;
    word_t  pc_next;
    instr_u ir_q;
    word_t  load_q;     // load data held for wb
    logic   branch_taken;

    // ==========================================================================
    // fsm
    // ==========================================================================
    always_comb begin
        case (state_q)
            ST_FETCH: state_d = ST_EXEC;
            ST_EXEC:  state_d = (dec_i.is_load || dec_i.is_store) ? ST_MEM : ST_WB;
            ST_MEM:   state_d = ST_WB;
            default:  state_d = ST_FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_FETCH;
            pc_q    <= RESET_PC;
            ir_q    <= NOP_INSTR;
        end else begin
            state_q <= state_d;
            if (state_q == ST_FETCH) begin
                ir_q <= instr_data_i;  // latch at end of fetch
            end
            if (state_q == ST_WB) begin
                pc_q <= pc_next;       // retire
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_MEM) begin
            load_q <= load_data_i;
        end
    end

    // ==========================================================================
    // branch and next pc
    // ==========================================================================
    always_comb begin
        case (dec_i.funct3)
            3'b000:         branch_taken = alu_zero_i;   // beq
            3'b001:         branch_taken = !alu_zero_i;  // bne
            3'b100, 3'b110: branch_taken = !alu_zero_i;  // blt/bltu, slt = 1
            3'b101, 3'b111: branch_taken = alu_zero_i;   // bge/bgeu, slt = 0
            default:        branch_taken = 1'b0;
        endcase
    end

    assign pc_plus4  = pc_q + 32'd4;
    assign pc_target = pc_q + dec_i.imm;

    always_comb begin
        if (dec_i.is_jal || (dec_i.is_branch && branch_taken)) begin
            pc_next = pc_target;
        end else if (dec_i.is_jalr) begin
            pc_next = {alu_result_i[XLEN-1:1], 1'b0};  // clear bit 0
        end else begin
            pc_next = pc_plus4;
        end
    end

    // writeback select
    always_comb begin
        if (dec_i.is_jal || dec_i.is_jalr) begin
            rf_wdata_o = pc_plus4;    // link
        end else if (dec_i.is_load) begin
            rf_wdata_o = load_q;
        end else begin
            rf_wdata_o = alu_result_i;
        end
    end

    assign rf_we_o  = (state_q == ST_WB) && dec_i.rd_we;
    assign mem_re_o = (state_q == ST_MEM) && dec_i.is_load;
    assign mem_we_o = (state_q == ST_MEM) && dec_i.is_store;  // write at end of mem
    assign pc_o     = pc_q;
    assign instr_o  = ir_q;

endmodule

// ==== design/rv_data_mem.sv ====
`timescale 1ns/1ps

module rv_data_mem import rv_pkg::*; #(
    parameter int DMEM_BYTES = 4096  // power of two, >= 64
) (
    input  logic       clk,
    input  logic       re_i,
    input  logic       we_i,
    input  logic [2:0] funct3_i,  // size / sign
    input  word_t      addr_i,    // byte address
    input  word_t      wdata_i,
    output word_t      rdata_o
);

    localparam int AW = $clog2(DMEM_BYTES);

    logic [7:0]    mem_q [DMEM_BYTES];  // little endian bytes
    logic [AW-1:0] a0;
    logic [AW-1:0] a1;
    logic [AW-1:0] a2;
    logic [AW-1:0] a3;
    logic          st_ok;
    logic          ld_ok;
    word_t         raw;

    assign a0 = addr_i[AW-1:0];
    assign a1 = a0 + AW'(1);
    assign a2 = a0 + AW'(2);
    assign a3 = a0 + AW'(3);

    // aligned stores fit once the first byte does
    assign st_ok = (addr_i < word_t'(DMEM_BYTES));
    assign ld_ok = (addr_i <= word_t'(DMEM_BYTES - 4));  // whole word inside

    // ==========================================================================
    // store lanes
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (we_i && st_ok) begin
            case (funct3_i)
                3'b000: mem_q[a0] <= wdata_i[7:0];  // sb
                3'b001: begin                       // sh, halfword aligned only
                    if (!addr_i[0]) begin
                        mem_q[a0] <= wdata_i[7:0];
                        mem_q[a1] <= wdata_i[15:8];
                    end
                end
                3'b010: begin                       // sw, word aligned only
                    if (addr_i[1:0] == 2'b00) begin
                        mem_q[a0] <= wdata_i[7:0];
                        mem_q[a1] <= wdata_i[15:8];
                        mem_q[a2] <= wdata_i[23:16];
                        mem_q[a3] <= wdata_i[31:24];
                    end
                end
                default: ;
            endcase
        end
    end

    // ==========================================================================
    // load path
    // ==========================================================================
    assign raw = (re_i && ld_ok) ? {mem_q[a3], mem_q[a2], mem_q[a1], mem_q[a0]} : '0;

    always_comb begin
        case (funct3_i)
            3'b000:  rdata_o = {{24{raw[7]}}, raw[7:0]};    // lb
            3'b001:  rdata_o = {{16{raw[15]}}, raw[15:0]};  // lh
            3'b100:  rdata_o = {24'b0, raw[7:0]};           // lbu
            3'b101:  rdata_o = {16'b0, raw[15:0]};          // lhu
            default: rdata_o = raw;                         // lw
        endcase
    end

endmodule

// ==== design/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
    input  dec_t  dec_i,
    input  word_t rs1_data_i,
    input  word_t rs2_data_i,
    input  word_t pc_i,        // for auipc
    output word_t result_o,
    output logic  zero_o       // branch compare
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;

    // operand a
    always_comb begin
        if (dec_i.is_lui) begin
            op_a = '0;           // 0 + imm
        end else if (dec_i.is_auipc) begin
            op_a = pc_i;
        end else begin
            op_a = rs1_data_i;
        end
    end

    assign op_b  = dec_i.use_imm ? dec_i.imm : rs2_data_i;  // branches keep rs2
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:  result_o = op_a + op_b;
            ALU_SUB:  result_o = op_a - op_b;
            ALU_SLL:  result_o = op_a << shamt;
            ALU_SLT:  result_o = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: result_o = word_t'(op_a < op_b);
            ALU_XOR:  result_o = op_a ^ op_b;
            ALU_SRL:  result_o = op_a >> shamt;
            ALU_SRA:  result_o = word_t'($signed(op_a) >>> shamt);  // sign fill
            ALU_OR:   result_o = op_a | op_b;
            ALU_AND:  result_o = op_a & op_b;
            default:  result_o = '0;
        endcase
    end

    assign zero_o = (result_o == '0);

endmodule

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_i,       // read port a
    input  reg_addr_t rs2_i,       // read port b
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o
);

    word_t regs_q [1:31];  // x0 is not stored

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin  // drop x0 writes
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // async reads, x0 hardwired
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

// ==== design/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
    input  instr_u instr_i,  // from instruction register
    output dec_t   dec_o
);

    // funct3/funct7 -> alu op, shared by reg and imm forms
    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic f7b5,
                                             input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && f7b5) ? ALU_SUB : ALU_ADD;  // no subi
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return f7b5 ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        dec_o        = '0;        // unknown opcode -> nop
        dec_o.alu_op = ALU_ADD;
        case (instr_i.r.opcode)
            OP_REG: begin
                dec_o.rd     = instr_i.r.rd;
                dec_o.rs1    = instr_i.r.rs1;
                dec_o.rs2    = instr_i.r.rs2;
                dec_o.funct3 = instr_i.r.funct3;
                dec_o.alu_op = funct_to_alu(instr_i.r.funct3, instr_i.r.funct7[5], 1'b1);
                dec_o.rd_we  = 1'b1;
            end
            OP_IMM, OP_LOAD, OP_JALR: begin
                dec_o.rd      = instr_i.i.rd;
                dec_o.rs1     = instr_i.i.rs1;
                dec_o.funct3  = instr_i.i.funct3;
                dec_o.imm     = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                dec_o.use_imm = 1'b1;
                dec_o.rd_we   = 1'b1;
                dec_o.is_load = (instr_i.i.opcode == OP_LOAD);
                dec_o.is_jalr = (instr_i.i.opcode == OP_JALR);
                if (instr_i.i.opcode == OP_IMM) begin
                    dec_o.alu_op = funct_to_alu(instr_i.i.funct3, instr_i.i.imm[10], 1'b0);
                end
            end
            OP_STORE: begin
                dec_o.rs1      = instr_i.s.rs1;
                dec_o.rs2      = instr_i.s.rs2;  // store data
                dec_o.funct3   = instr_i.s.funct3;
                dec_o.imm      = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
                dec_o.use_imm  = 1'b1;
                dec_o.is_store = 1'b1;
            end
            OP_BRANCH: begin
                dec_o.rs1       = instr_i.b.rs1;
                dec_o.rs2       = instr_i.b.rs2;
                dec_o.funct3    = instr_i.b.funct3;
                dec_o.imm       = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                                   instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
                dec_o.is_branch = 1'b1;
                case (instr_i.b.funct3)
                    3'b000, 3'b001: dec_o.alu_op = ALU_SUB;   // beq/bne via zero
                    3'b110, 3'b111: dec_o.alu_op = ALU_SLTU;  // bltu/bgeu
                    default:        dec_o.alu_op = ALU_SLT;   // blt/bge
                endcase
            end
            OP_LUI, OP_AUIPC: begin
                dec_o.rd       = instr_i.u.rd;
                dec_o.imm      = {instr_i.u.imm, 12'b0};
                dec_o.use_imm  = 1'b1;
                dec_o.rd_we    = 1'b1;
                dec_o.is_lui   = (instr_i.u.opcode == OP_LUI);
                dec_o.is_auipc = (instr_i.u.opcode == OP_AUIPC);
            end
            OP_JAL: begin
                dec_o.rd     = instr_i.j.rd;
                dec_o.imm    = {{11{instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
                                instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};
                dec_o.rd_we  = 1'b1;
                dec_o.is_jal = 1'b1;
            end
            default: ;
        endcase
        dec_o.rd_we = dec_o.rd_we && (dec_o.rd != '0);  // x0 never written
    end

endmodule

// ==== design/rv_pkg.sv ====
package rv_pkg;

    // ==========================================================================
    // basic widths
    // ==========================================================================
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;     // data / address word
    typedef logic [4:0]      reg_addr_t; // x0..x31

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_SLL  = 4'b0010,
        ALU_SLT  = 4'b0011,  // signed compare
        ALU_SLTU = 4'b0100,  // unsigned compare
        ALU_XOR  = 4'b0101,
        ALU_SRL  = 4'b0110,
        ALU_SRA  = 4'b0111,
        ALU_OR   = 4'b1000,
        ALU_AND  = 4'b1001
    } alu_op_e;

    // ==========================================================================
    // instruction formats, msb first
    // ==========================================================================
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;  // imm[11:0], imm[10] is the srai bit
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;  // imm[11:5]
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;  // imm[4:0]
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;  // imm[31:12]
        reg_addr_t   rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        opcode_e    opcode;
    } j_fmt_t;

    // one word, six views; opcode sits in the same bits everywhere
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;        // sign-extended
        alu_op_e    alu_op;
        logic [2:0] funct3;     // branch cond / mem size
        logic       use_imm;    // alu b = imm
        logic       rd_we;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       is_lui;
        logic       is_auipc;
    } dec_t;

    localparam word_t NOP_INSTR = 32'h0000_0013;  // addi x0,x0,0

endpackage
